/* Bender.yml */
package:
  name: apbI2c

export_include_dirs:
  - common

sources:
  - common/apbI2c_pkg.sv
  - hw/byteFifo.sv
  - hw/apbRegs.sv
  - i2cMaster/i2cShift.sv
  - i2cMaster/i2cBitTimer.sv
  - i2cMaster/i2cCtrl.sv
  - hw/apbI2cTop.sv
  - target: simulation
    files:
      - verif/tbClock.sv
      - verif/i2cSlaveModel.sv
      - verif/apbI2cTb.sv

/* common/apbI2c_macros.svh */
// Register map and sizing constants, included by blocks that decode addresses or size FIFOs
`ifndef APBI2C_MACROS_SVH
`define APBI2C_MACROS_SVH

// APB register addresses
`define APBI2C_ADDR_TX      32'd0
`define APBI2C_ADDR_RX      32'd4
`define APBI2C_ADDR_CFG     32'd8
`define APBI2C_ADDR_TIMEOUT 32'd12
`define APBI2C_ADDR_STATUS  32'd16

// Entries in each of the TX and RX queues
`define APBI2C_FIFO_DEPTH 4

// 7-bit address answered by the behavioural slave
`define APBI2C_SLAVE_ADDR 7'h50

`endif

/* common/apbI2c_pkg.sv */
// Shared types for the APB I2C master, referenced by scoped names from every block
package apbI2c_pkg;

	//////////////////////////////
	// Plain widths
	//////////////////////////////

	// APB address and data word
	typedef logic [31:0] apbWord_t;
	// One byte on the I2C bus
	typedef logic [7:0] i2cByte_t;
	// Payload of the CONFIG and TIMEOUT registers
	typedef logic [13:0] cfgWord_t;

	//////////////////////////////
	// Structs
	//////////////////////////////

	// One TX FIFO entry, taken from PWDATA[11:0]
	typedef struct packed {
		logic start;
		logic stop;
		logic read;
		logic nackLast;
		i2cByte_t data;
	} i2cCmd_t;

	// CONFIG holds enable and half period, TIMEOUT holds the longest stretch
	typedef struct packed {
		logic enable;
		logic [12:0] halfPeriod;
		cfgWord_t timeout;
	} i2cCfg_t;

	// Status register layout, PRDATA[5:0]
	typedef struct packed {
		logic busy;
		logic error;
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
	} i2cStatus_t;

	// Controller sequencing states
	typedef enum logic [2:0] {
		IDLE,
		START,
		BIT_LOW,
		BIT_HIGH,
		ACK_LOW,
		ACK_HIGH,
		STOP,
		FLUSH
	} ctrlState_t;

endpackage

/* filelist.f */
+incdir+common
common/apbI2c_pkg.sv
hw/byteFifo.sv
hw/apbRegs.sv
i2cMaster/i2cShift.sv
i2cMaster/i2cBitTimer.sv
i2cMaster/i2cCtrl.sv
hw/apbI2cTop.sv
verif/tbClock.sv
verif/i2cSlaveModel.sv
verif/apbI2cTb.sv

/* hw/apbI2cTop.sv */
// Top level of the APB I2C master, wires registers, queues and the bus engine together
`timescale 1ns/10ps
`include "apbI2c_macros.svh"

module apbI2cTop (
	input	logic					PCLK,
	input	logic					PRESETn,
	input	logic					PSELx,
	input	logic					PENABLE,
	input	logic					PWRITE,
	input	apbI2c_pkg::apbWord_t	PADDR,
	input	apbI2c_pkg::apbWord_t	PWDATA,
	input	logic					sclIn,
	input	logic					sdaIn,
	output	apbI2c_pkg::apbWord_t	PRDATA,
	output	logic					PREADY,
	output	logic					PSLVERR,
	output	logic					sclLow,
	output	logic					sdaLow,
	output	logic					intTx,
	output	logic					intRx
);
	logic txPush;
	logic txPop;
	logic txFlush;
	logic txFull;
	logic txEmpty;
	logic rxPush;
	logic rxPop;
	logic rxFull;
	logic rxEmpty;
	logic errSet;
	logic error;
	logic busy;
	logic timerRun;
	logic halfDone;
	logic tmoExpired;
	logic load;
	logic shiftBit;
	logic sampleBit;
	logic sdaBit;
	logic ackIn;
	apbI2c_pkg::i2cCmd_t txCmd;
	apbI2c_pkg::i2cCmd_t txHead;
	apbI2c_pkg::i2cByte_t rxHead;
	apbI2c_pkg::i2cByte_t rxByte;
	apbI2c_pkg::i2cByte_t loadByte;
	apbI2c_pkg::i2cCfg_t cfg;
	apbI2c_pkg::i2cStatus_t status;

	// Status word gathered from the engine, error flag and both queues
	assign status = '{busy: busy, error: error, txFull: txFull, txEmpty: txEmpty,
		rxFull: rxFull, rxEmpty: rxEmpty};

	apbRegs regs0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE),
		.PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .rxHead(rxHead),
		.status(status), .errSet(errSet), .PRDATA(PRDATA), .PREADY(PREADY),
		.PSLVERR(PSLVERR), .txPush(txPush), .txCmd(txCmd), .rxPop(rxPop),
		.cfg(cfg), .error(error), .intTx(intTx), .intRx(intRx)
	);

	//////////////////////////////
	// Command and receive queues
	//////////////////////////////
	byteFifo #(.WIDTH($bits(apbI2c_pkg::i2cCmd_t)), .DEPTH(`APBI2C_FIFO_DEPTH)) txFifo0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pushData(txCmd),
		.pop(txPop), .flush(txFlush), .headData(txHead), .full(txFull), .empty(txEmpty)
	);

	// RX queue is never flushed, received bytes wait for the host
	byteFifo #(.WIDTH($bits(apbI2c_pkg::i2cByte_t)), .DEPTH(`APBI2C_FIFO_DEPTH)) rxFifo0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush), .pushData(rxByte),
		.pop(rxPop), .flush(1'b0), .headData(rxHead), .full(rxFull), .empty(rxEmpty)
	);

	//////////////////////////////
	// Bus engine
	//////////////////////////////
	i2cCtrl ctrl0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .cfg(cfg), .error(error), .txHead(txHead),
		.txEmpty(txEmpty), .rxFull(rxFull), .halfDone(halfDone), .tmoExpired(tmoExpired),
		.ackIn(ackIn), .sdaBitIn(sdaBit), .txPop(txPop), .txFlush(txFlush),
		.rxPush(rxPush), .errSet(errSet), .busy(busy), .timerRun(timerRun), .load(load),
		.loadByte(loadByte), .shiftBit(shiftBit), .sampleBit(sampleBit),
		.sclLow(sclLow), .sdaLow(sdaLow)
	);

	i2cBitTimer timer0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .run(timerRun), .halfPeriod(cfg.halfPeriod),
		.timeout(cfg.timeout), .sclDriven(sclLow), .sclIn(sclIn),
		.halfDone(halfDone), .tmoExpired(tmoExpired)
	);

	i2cShift shift0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .load(load), .loadByte(loadByte),
		.shiftBit(shiftBit), .sampleBit(sampleBit), .sdaIn(sdaIn),
		.sdaBit(sdaBit), .rxByte(rxByte), .ackIn(ackIn)
	);

endmodule

/* hw/apbRegs.sv */
// APB slave register block, turns zero-wait transfers into FIFO strobes and config writes
`timescale 1ns/10ps
`include "apbI2c_macros.svh"

module apbRegs (
	input	logic					PCLK,
	input	logic					PRESETn,
	input	logic					PSELx,
	input	logic					PENABLE,
	input	logic					PWRITE,
	input	apbI2c_pkg::apbWord_t	PADDR,
	input	apbI2c_pkg::apbWord_t	PWDATA,
	input	apbI2c_pkg::i2cByte_t	rxHead,
	input	apbI2c_pkg::i2cStatus_t	status,
	input	logic					errSet,
	output	apbI2c_pkg::apbWord_t	PRDATA,
	output	logic					PREADY,
	output	logic					PSLVERR,
	output	logic					txPush,
	output	apbI2c_pkg::i2cCmd_t	txCmd,
	output	logic					rxPop,
	output	apbI2c_pkg::i2cCfg_t	cfg,
	output	logic					error,
	output	logic					intTx,
	output	logic					intRx
);
	logic access;
	logic wrAcc;
	logic rdAcc;
	logic selTx;
	logic selRx;
	logic selCfg;
	logic selTmo;
	logic selStatus;
	logic mapped;
	apbI2c_pkg::cfgWord_t cfgReg;
	apbI2c_pkg::cfgWord_t tmoReg;

	// Access phase, no wait states
	assign access = PSELx & PENABLE;
	assign wrAcc = access & PWRITE;
	assign rdAcc = access & ~PWRITE;
	assign PREADY = access;

	// Address decode
	assign selTx = (PADDR == `APBI2C_ADDR_TX);
	assign selRx = (PADDR == `APBI2C_ADDR_RX);
	assign selCfg = (PADDR == `APBI2C_ADDR_CFG);
	assign selTmo = (PADDR == `APBI2C_ADDR_TIMEOUT);
	assign selStatus = (PADDR == `APBI2C_ADDR_STATUS);
	assign mapped = selTx | selRx | selCfg | selTmo | selStatus;

	// Queue strobes, a full TX drops the entry and an empty RX pops nothing
	assign txPush = wrAcc & selTx & ~status.txFull;
	assign txCmd = apbI2c_pkg::i2cCmd_t'(PWDATA[11:0]);
	assign rxPop = rdAcc & selRx & ~status.rxEmpty;

	// Slave error while sticky error is up, on overflow, underflow or a hole in the map
	assign PSLVERR = access & (error | ~mapped | (wrAcc & selTx & status.txFull)
		| (rdAcc & selRx & status.rxEmpty));

	// Top bit of CONFIG enables the engine, the rest is the SCL half period
	assign cfg = '{enable: cfgReg[13], halfPeriod: cfgReg[12:0], timeout: tmoReg};

	// Interrupt levels follow the queue state directly
	assign intTx = status.txEmpty;
	assign intRx = ~status.rxEmpty;

	// Read data mux
	always_comb
	begin
		PRDATA = '0;
		if (selRx)
			PRDATA = {24'd0, rxHead};
		else if (selCfg)
			PRDATA = {18'd0, cfgReg};
		else if (selTmo)
			PRDATA = {18'd0, tmoReg};
		else if (selStatus)
			PRDATA = {26'd0, status};
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg <= '0;
			tmoReg <= '0;
			error <= 1'b0;
		end
		else
		begin
			if (wrAcc & selCfg)
				cfgReg <= PWDATA[13:0];
			if (wrAcc & selTmo)
				tmoReg <= PWDATA[13:0];
			// A new fault wins over a clearing CONFIG write in the same cycle
			if (errSet)
				error <= 1'b1;
			else if (wrAcc & selCfg)
				error <= 1'b0;
		end
	end

endmodule

/* hw/byteFifo.sv */
// Synchronous circular FIFO with flush, sized per instance for the TX and RX queues
`timescale 1ns/10ps

module byteFifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input	logic				PCLK,
	input	logic				PRESETn,
	input	logic				push,
	input	logic [WIDTH-1:0]	pushData,
	input	logic				pop,
	input	logic				flush,
	output	logic [WIDTH-1:0]	headData,
	output	logic				full,
	output	logic				empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	logic [AW:0] count;
	logic doPush;
	logic doPop;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);
	// Overflow and underflow requests are dropped here
	assign doPush = push & ~full;
	assign doPop = pop & ~empty;
	// Head shown without a read cycle
	assign headData = mem[rdPtr];

	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (doPush)
				wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + (AW+1)'(doPush) - (AW+1)'(doPop);
		end
	end

endmodule

/* i2cMaster/i2cBitTimer.sv */
// SCL half-period timer with clock-stretch detection and timeout for the I2C master
`timescale 1ns/10ps

module i2cBitTimer (
	input	logic					PCLK,
	input	logic					PRESETn,
	input	logic					run,
	input	logic [12:0]			halfPeriod,
	input	apbI2c_pkg::cfgWord_t	timeout,
	input	logic					sclDriven,
	input	logic					sclIn,
	output	logic					halfDone,
	output	logic					tmoExpired
);
	logic [12:0] halfCnt;
	apbI2c_pkg::cfgWord_t stretchCnt;
	logic lineOk;
	logic stretching;

	// sclDriven is high while the master pulls SCL low
	assign lineOk = (sclDriven != sclIn);
	// Released by the master but held low by a slave
	assign stretching = run & ~sclDriven & ~sclIn;

	// Half period of halfPeriod cycles, minimum 2
	assign halfDone = run & lineOk & (halfCnt >= halfPeriod - 13'd1);
	// Fires once the stretch has lasted longer than timeout cycles
	assign tmoExpired = stretching & (stretchCnt >= timeout);

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			halfCnt <= '0;
			stretchCnt <= '0;
		end
		else
		begin
			// Count pauses while the sensed line disagrees with the driven one
			if (!run || halfDone)
				halfCnt <= '0;
			else if (lineOk)
				halfCnt <= halfCnt + 13'd1;
			if (!stretching)
				stretchCnt <= '0;
			else if (stretchCnt != '1)
				stretchCnt <= stretchCnt + 14'd1;
		end
	end

endmodule

/* i2cMaster/i2cCtrl.sv */
// I2C master sequencer, runs one TX command through start, nine clocks and stop
`timescale 1ns/10ps

module i2cCtrl (
	input	logic					PCLK,
	input	logic					PRESETn,
	input	apbI2c_pkg::i2cCfg_t	cfg,
	input	logic					error,
	input	apbI2c_pkg::i2cCmd_t	txHead,
	input	logic					txEmpty,
	input	logic					rxFull,
	input	logic					halfDone,
	input	logic					tmoExpired,
	input	logic					ackIn,
	input	logic					sdaBitIn,
	output	logic					txPop,
	output	logic					txFlush,
	output	logic					rxPush,
	output	logic					errSet,
	output	logic					busy,
	output	logic					timerRun,
	output	logic					load,
	output	apbI2c_pkg::i2cByte_t	loadByte,
	output	logic					shiftBit,
	output	logic					sampleBit,
	output	logic					sclLow,
	output	logic					sdaLow
);
	apbI2c_pkg::ctrlState_t state;
	apbI2c_pkg::ctrlState_t stateNext;
	apbI2c_pkg::i2cCmd_t cmd;
	logic [1:0] phase;
	logic [2:0] bitCnt;
	logic busHeld;
	logic errPending;
	logic ackWait;
	logic sdaNext;
	logic lastPhase;
	logic nack;
	logic ackDrive;
	// Current bit being driven, high means release
	logic sdaBitMsb;

	// Sub-phase of START and STOP, three half periods each
	assign lastPhase = (phase == 2'd2);
	// Only a written byte can be refused
	assign nack = ~cmd.read & ackIn;
	// Master pulls SDA low in the acknowledge slot of a read unless told to NACK
	assign ackDrive = cmd.read & ~cmd.nackLast;

	assign busy = (state != apbI2c_pkg::IDLE);
	assign timerRun = busy & (state != apbI2c_pkg::FLUSH);
	assign txFlush = (state == apbI2c_pkg::FLUSH);
	// Take a command only when enabled, error free and something is queued
	assign txPop = (state == apbI2c_pkg::IDLE) & cfg.enable & ~error & ~txEmpty;
	assign load = txPop;
	// Reads shift out all ones so SDA stays released
	assign loadByte = txHead.read ? 8'hFF : txHead.data;

	//////////////////////////////
	// Next state and strobes
	//////////////////////////////
	always_comb
	begin
		stateNext = state;
		shiftBit = 1'b0;
		sampleBit = 1'b0;
		rxPush = 1'b0;
		errSet = 1'b0;
		sclLow = 1'b1;
		sdaNext = 1'b0;
		case (state)
			apbI2c_pkg::IDLE:
			begin
				// SCL stays low between commands of one transfer
				sclLow = busHeld;
				if (txPop)
					stateNext = txHead.start ? apbI2c_pkg::START : apbI2c_pkg::BIT_LOW;
			end
			apbI2c_pkg::START:
			begin
				// Release SDA, raise SCL, then drop SDA while SCL is high
				sclLow = (phase == 2'd0) & busHeld;
				sdaNext = lastPhase;
				if (tmoExpired)
				begin
					errSet = 1'b1;
					stateNext = apbI2c_pkg::STOP;
				end
				else if (halfDone & lastPhase)
					stateNext = apbI2c_pkg::BIT_LOW;
			end
			apbI2c_pkg::BIT_LOW:
			begin
				sdaNext = ~sdaBitMsb;
				if (halfDone)
					stateNext = apbI2c_pkg::BIT_HIGH;
			end
			apbI2c_pkg::BIT_HIGH:
			begin
				sclLow = 1'b0;
				sdaNext = ~sdaBitMsb;
				if (tmoExpired)
				begin
					errSet = 1'b1;
					stateNext = apbI2c_pkg::STOP;
				end
				else if (halfDone)
				begin
					// Sample at the end of the high half, SDA is stable there
					sampleBit = 1'b1;
					if (bitCnt == 3'd7)
						stateNext = apbI2c_pkg::ACK_LOW;
					else
					begin
						shiftBit = 1'b1;
						stateNext = apbI2c_pkg::BIT_LOW;
					end
				end
			end
			apbI2c_pkg::ACK_LOW:
			begin
				sdaNext = ackDrive;
				// Back-pressure, SCL held low until the RX queue has room
				if (halfDone & (~cmd.read | ~rxFull))
				begin
					rxPush = cmd.read;
					stateNext = apbI2c_pkg::ACK_HIGH;
				end
			end
			apbI2c_pkg::ACK_HIGH:
			begin
				sclLow = 1'b0;
				sdaNext = ackDrive;
				if (tmoExpired)
				begin
					errSet = 1'b1;
					stateNext = apbI2c_pkg::STOP;
				end
				else if (ackWait)
				begin
					// One extra cycle high lets the sampled acknowledge settle
					if (nack)
					begin
						errSet = 1'b1;
						stateNext = apbI2c_pkg::STOP;
					end
					else
						stateNext = cmd.stop ? apbI2c_pkg::STOP : apbI2c_pkg::IDLE;
				end
				else if (halfDone)
					sampleBit = 1'b1;
			end
			apbI2c_pkg::STOP:
			begin
				// SDA low with SCL low, raise SCL, then release SDA
				sclLow = (phase == 2'd0);
				sdaNext = ~lastPhase;
				if (tmoExpired)
				begin
					// Slave still holds SCL, give up on the stop
					errSet = 1'b1;
					stateNext = apbI2c_pkg::FLUSH;
				end
				else if (halfDone & lastPhase)
					stateNext = errPending ? apbI2c_pkg::FLUSH : apbI2c_pkg::IDLE;
			end
			apbI2c_pkg::FLUSH:
			begin
				sclLow = 1'b0;
				stateNext = apbI2c_pkg::IDLE;
			end
			default:
				stateNext = apbI2c_pkg::IDLE;
		endcase
	end

	assign sdaBitMsb = sdaBitIn;

	always_ff @(posedge PCLK)
	begin
		if (txPop)
			cmd <= txHead;
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= apbI2c_pkg::IDLE;
			phase <= '0;
			bitCnt <= '0;
			busHeld <= 1'b0;
			errPending <= 1'b0;
			ackWait <= 1'b0;
			sdaLow <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// SDA lags SCL by one cycle so it never moves on an SCL edge
			sdaLow <= sdaNext;
			if (stateNext != state)
				phase <= '0;
			else if (halfDone)
				phase <= phase + 2'd1;
			if (txPop)
				bitCnt <= '0;
			else if (sampleBit & (state == apbI2c_pkg::BIT_HIGH))
				bitCnt <= bitCnt + 3'd1;
			ackWait <= sampleBit & (state == apbI2c_pkg::ACK_HIGH);
			if ((state == apbI2c_pkg::ACK_HIGH) & (stateNext == apbI2c_pkg::IDLE))
				busHeld <= 1'b1;
			else if (state == apbI2c_pkg::STOP)
				busHeld <= 1'b0;
			if (errSet)
				errPending <= 1'b1;
			else if (state == apbI2c_pkg::FLUSH)
				errPending <= 1'b0;
		end
	end

endmodule

/* i2cMaster/i2cShift.sv */
// Byte shifter for the I2C master, drives SDA bits MSB first and captures data and ACK
`timescale 1ns/10ps

module i2cShift (
	input	logic					PCLK,
	input	logic					PRESETn,
	input	logic					load,
	input	apbI2c_pkg::i2cByte_t	loadByte,
	input	logic					shiftBit,
	input	logic					sampleBit,
	input	logic					sdaIn,
	output	logic					sdaBit,
	output	apbI2c_pkg::i2cByte_t	rxByte,
	output	logic					ackIn
);
	apbI2c_pkg::i2cByte_t txReg;
	logic [3:0] sampleCnt;

	// MSB goes on the wire first
	assign sdaBit = txReg[7];

	always_ff @(posedge PCLK)
	begin
		// Fill with ones so a finished byte leaves SDA released
		if (load)
			txReg <= loadByte;
		else if (shiftBit)
			txReg <= {txReg[6:0], 1'b1};
		// First eight samples form the data byte
		if (sampleBit && (sampleCnt < 4'd8))
			rxByte <= {rxByte[6:0], sdaIn};
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			sampleCnt <= '0;
			ackIn <= 1'b1;
		end
		else if (load)
			sampleCnt <= '0;
		else if (sampleBit)
		begin
			// Ninth sample is the acknowledge, low means ACK
			if (sampleCnt == 4'd8)
				ackIn <= sdaIn;
			else
				sampleCnt <= sampleCnt + 4'd1;
		end
	end

endmodule

/* verif/apbI2cTb.sv */
// Testbench top for the APB I2C master that checks random traffic against a byte queue model
`timescale 1ns/10ps
`include "apbI2c_macros.svh"

module apbI2cTb;
	logic PCLK;
	logic PRESETn;
	logic PSELx;
	logic PENABLE;
	logic PWRITE;
	apbI2c_pkg::apbWord_t PADDR;
	apbI2c_pkg::apbWord_t PWDATA;
	apbI2c_pkg::apbWord_t PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic sclLowDut;
	logic sdaLowDut;
	logic sclLowSlv;
	logic sdaLowSlv;
	logic intTx;
	logic intRx;
	wire scl;
	wire sda;
	int stretchCycles;
	int seed;
	int errCount;
	int failCount;
	apbI2c_pkg::i2cByte_t modelQ[$];

	// Open-drain bus where either side pulling low wins
	assign scl = ~(sclLowDut | sclLowSlv);
	assign sda = ~(sdaLowDut | sdaLowSlv);

	tbClock clk0 (.PCLK(PCLK), .PRESETn(PRESETn));

	apbI2cTop dut0 (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE),
		.PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .sclIn(scl), .sdaIn(sda),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR), .sclLow(sclLowDut),
		.sdaLow(sdaLowDut), .intTx(intTx), .intRx(intRx)
	);

	i2cSlaveModel slave0 (
		.PCLK(PCLK), .scl(scl), .sda(sda), .stretchCycles(stretchCycles),
		.sclLow(sclLowSlv), .sdaLow(sdaLowSlv)
	);

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkApbWord(input string name, input apbI2c_pkg::apbWord_t exp,
		input apbI2c_pkg::apbWord_t act);
		if (exp !== act)
		begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkByte(input string name, input apbI2c_pkg::i2cByte_t exp,
		input apbI2c_pkg::i2cByte_t act);
		if (exp !== act)
		begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkStatus(input string name, input apbI2c_pkg::i2cStatus_t exp,
		input apbI2c_pkg::i2cStatus_t act);
		if (exp !== act)
		begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			errCount++;
		end
	endtask

	//////////////////////////////
	// APB access
	//////////////////////////////
	// Setup, access, then sample the access phase on the closing edge
	task automatic apbXfer(input logic wr, input apbI2c_pkg::apbWord_t addr,
		input apbI2c_pkg::apbWord_t wdata, output apbI2c_pkg::apbWord_t rdata,
		output logic err);
		@(posedge PCLK);
		PSELx <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE <= wr;
		PADDR <= addr;
		PWDATA <= wdata;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		@(posedge PCLK);
		rdata = PRDATA;
		err = PSLVERR;
		checkFlag("apbReady", 1'b1, PREADY);
		PSELx <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic readStatus(output apbI2c_pkg::i2cStatus_t st);
		apbI2c_pkg::apbWord_t rd;
		logic err;
		apbXfer(1'b0, `APBI2C_ADDR_STATUS, '0, rd, err);
		st = apbI2c_pkg::i2cStatus_t'(rd[5:0]);
	endtask

	// TX entry layout is bit 11 start, 10 stop, 9 read, 8 nackLast and 7..0 data
	task automatic pushCmd(input string name, input logic start, input logic stop,
		input logic read, input logic nack, input apbI2c_pkg::i2cByte_t data,
		input logic expErr);
		apbI2c_pkg::apbWord_t rd;
		logic err;
		apbXfer(1'b1, `APBI2C_ADDR_TX, {20'd0, start, stop, read, nack, data}, rd, err);
		checkFlag(name, expErr, err);
	endtask

	// Poll status until the engine is idle and the TX queue has drained
	task automatic waitIdle(input string name);
		apbI2c_pkg::i2cStatus_t st;
		int i;
		for (i = 0; i < 4000; i++)
		begin
			readStatus(st);
			if (!st.busy && st.txEmpty)
				break;
		end
		if (i == 4000)
		begin
			$display("%s: engine still busy after polling limit", name);
			failCount++;
		end
	endtask

	task automatic waitSlaveRelease(input string name);
		int i;
		for (i = 0; i < 2000 && sclLowSlv; i++)
			@(posedge PCLK);
		if (sclLowSlv)
		begin
			$display("%s: slave never released SCL", name);
			failCount++;
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial
	begin : main
		apbI2c_pkg::apbWord_t rd;
		apbI2c_pkg::apbWord_t val;
		apbI2c_pkg::i2cStatus_t st;
		logic err;
		int n;
		int i;

		PSELx = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		stretchCycles = 0;
		seed = 32'h7f938eeb;
		errCount = 0;
		failCount = 0;

		for (i = 0; i < 50 && !PRESETn; i++)
			@(posedge PCLK);
		if (!PRESETn)
		begin
			$display("Reset never released");
			failCount++;
		end
		@(posedge PCLK);
		checkFlag("resetIntTx", 1'b1, intTx);
		checkFlag("resetIntRx", 1'b0, intRx);
		checkFlag("resetReady", 1'b0, PREADY);
		checkFlag("resetSlvErr", 1'b0, PSLVERR);
		checkFlag("resetScl", 1'b0, sclLowDut);
		checkFlag("resetSda", 1'b0, sdaLowDut);
		readStatus(st);
		checkStatus("resetStatus", 6'b000101, st);

		// Register access with random payloads
		val = $random(seed);
		apbXfer(1'b1, `APBI2C_ADDR_CFG, val, rd, err);
		apbXfer(1'b0, `APBI2C_ADDR_CFG, '0, rd, err);
		checkApbWord("regCfg", val & 32'h3fff, rd);
		checkFlag("regCfgErr", 1'b0, err);
		val = $random(seed);
		apbXfer(1'b1, `APBI2C_ADDR_TIMEOUT, val, rd, err);
		apbXfer(1'b0, `APBI2C_ADDR_TIMEOUT, '0, rd, err);
		checkApbWord("regTmo", val & 32'h3fff, rd);
		checkFlag("regTmoErr", 1'b0, err);
		apbXfer(1'b0, 32'h20, '0, rd, err);
		checkFlag("regUnmapped", 1'b1, err);
		checkApbWord("regUnmappedData", 32'd0, rd);

		// Enable with half period 4 and a generous timeout
		apbXfer(1'b1, `APBI2C_ADDR_CFG, 32'h2004, rd, err);
		apbXfer(1'b1, `APBI2C_ADDR_TIMEOUT, 32'd200, rd, err);

		// Write transfer
		n = 1 + ($unsigned($random(seed)) % 3);
		pushCmd("wrAddr", 1'b1, 1'b0, 1'b0, 1'b0, {`APBI2C_SLAVE_ADDR, 1'b0}, 1'b0);
		for (i = 0; i < n; i++)
		begin
			val = $random(seed);
			modelQ.push_back(val[7:0]);
			pushCmd("wrData", 1'b0, (i == n - 1), 1'b0, 1'b0, val[7:0], 1'b0);
		end
		waitIdle("wrIdle");
		checkApbWord("wrCount", n, slave0.dataQ.size());
		for (i = 0; i < n && i < slave0.dataQ.size(); i++)
			checkByte("wrByte", modelQ[i], slave0.dataQ[i]);
		checkFlag("wrIntTx", 1'b1, intTx);
		readStatus(st);
		checkFlag("wrError", 1'b0, st.error);

		// Read transfer behind a repeated start where the slave replays its queue
		pushCmd("rdWrAddr", 1'b1, 1'b0, 1'b0, 1'b0, {`APBI2C_SLAVE_ADDR, 1'b0}, 1'b0);
		pushCmd("rdAddr", 1'b1, 1'b0, 1'b0, 1'b0, {`APBI2C_SLAVE_ADDR, 1'b1}, 1'b0);
		for (i = 0; i < n; i++)
			pushCmd("rdCmd", 1'b0, (i == n - 1), 1'b1, (i == n - 1), 8'h00, 1'b0);
		for (i = 0; i < 4000 && !intRx; i++)
			@(posedge PCLK);
		if (!intRx)
		begin
			$display("rdIntRx: RX interrupt never rose");
			failCount++;
		end
		waitIdle("rdIdle");
		for (i = 0; i < n; i++)
		begin
			apbXfer(1'b0, `APBI2C_ADDR_RX, '0, rd, err);
			checkByte("rdByte", modelQ.pop_front(), rd[7:0]);
			checkFlag("rdErr", 1'b0, err);
		end

		// Wrong address is refused
		pushCmd("nackAddr", 1'b1, 1'b0, 1'b0, 1'b0, {7'h51, 1'b0}, 1'b0);
		pushCmd("nackData", 1'b0, 1'b1, 1'b0, 1'b0, 8'hA5, 1'b0);
		waitIdle("nackIdle");
		readStatus(st);
		checkStatus("nackStatus", 6'b010101, st);
		apbXfer(1'b0, `APBI2C_ADDR_CFG, '0, rd, err);
		checkFlag("nackSlvErr", 1'b1, err);
		apbXfer(1'b1, `APBI2C_ADDR_CFG, 32'h2004, rd, err);
		apbXfer(1'b0, `APBI2C_ADDR_STATUS, '0, rd, err);
		checkFlag("nackCleared", 1'b0, rd[4]);
		checkFlag("nackClearedErr", 1'b0, err);

		// Long stretch runs past the timeout
		apbXfer(1'b1, `APBI2C_ADDR_TIMEOUT, 32'd40, rd, err);
		stretchCycles = 120;
		pushCmd("tmoAddr", 1'b1, 1'b0, 1'b0, 1'b0, {`APBI2C_SLAVE_ADDR, 1'b0}, 1'b0);
		pushCmd("tmoData", 1'b0, 1'b1, 1'b0, 1'b0, 8'h3C, 1'b0);
		waitIdle("tmoIdle");
		readStatus(st);
		checkFlag("tmoError", 1'b1, st.error);
		stretchCycles = 0;
		waitSlaveRelease("tmoRelease");
		apbXfer(1'b1, `APBI2C_ADDR_CFG, 32'h2004, rd, err);
		slave0.dataQ.delete();

		// Short stretch completes normally
		stretchCycles = 10;
		val = $random(seed);
		pushCmd("shortAddr", 1'b1, 1'b0, 1'b0, 1'b0, {`APBI2C_SLAVE_ADDR, 1'b0}, 1'b0);
		pushCmd("shortData", 1'b0, 1'b1, 1'b0, 1'b0, val[7:0], 1'b0);
		waitIdle("shortIdle");
		readStatus(st);
		checkFlag("shortError", 1'b0, st.error);
		checkApbWord("shortCount", 32'd1, slave0.dataQ.size());
		if (slave0.dataQ.size() > 0)
			checkByte("shortByte", val[7:0], slave0.dataQ[0]);
		stretchCycles = 0;

		// Queue limits with the engine stopped
		apbXfer(1'b1, `APBI2C_ADDR_CFG, 32'h0004, rd, err);
		for (i = 0; i < `APBI2C_FIFO_DEPTH; i++)
		begin
			val = $random(seed);
			pushCmd("fifoFill", 1'b0, 1'b0, 1'b0, 1'b0, val[7:0], 1'b0);
		end
		pushCmd("fifoOverflow", 1'b0, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1);
		readStatus(st);
		checkStatus("fifoStatus", 6'b001001, st);
		apbXfer(1'b0, `APBI2C_ADDR_RX, '0, rd, err);
		checkFlag("fifoUnderflow", 1'b1, err);

		$display("Errors: %0d value mismatches, %0d other failures", errCount, failCount);
		if (errCount == 0 && failCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verif/i2cSlaveModel.sv */
// Behavioural I2C slave for the testbench that ACKs its address, queues written bytes and replays them
`timescale 1ns/10ps
`include "apbI2c_macros.svh"

module i2cSlaveModel #(
	parameter logic [6:0] ADDR = `APBI2C_SLAVE_ADDR
) (
	input	logic	PCLK,
	input	logic	scl,
	input	logic	sda,
	input	int		stretchCycles,
	output	logic	sclLow,
	output	logic	sdaLow
);
	apbI2c_pkg::i2cByte_t dataQ[$];
	apbI2c_pkg::i2cByte_t shiftReg;
	apbI2c_pkg::i2cByte_t rdByte;
	logic active;
	logic addrPhase;
	logic matched;
	logic rw;
	logic masterAck;
	int bitCnt;

	initial
	begin
		sclLow = 1'b0;
		sdaLow = 1'b0;
		active = 1'b0;
		addrPhase = 1'b0;
		matched = 1'b0;
		rw = 1'b0;
		masterAck = 1'b0;
		bitCnt = 0;
	end

	//////////////////////////////
	// Start and stop detection
	//////////////////////////////
	always @(negedge sda)
	begin
		if (scl)
		begin
			active = 1'b1;
			addrPhase = 1'b1;
			matched = 1'b0;
			bitCnt = 0;
			sdaLow = 1'b0;
		end
	end

	always @(posedge sda)
	begin
		if (scl)
		begin
			active = 1'b0;
			sdaLow = 1'b0;
		end
	end

	// Bits are sampled on the rising SCL edge and the ninth one is the master's acknowledge
	always @(posedge scl)
	begin
		if (active)
		begin
			if (bitCnt < 8)
			begin
				shiftReg = {shiftReg[6:0], sda};
				bitCnt = bitCnt + 1;
			end
			else if (bitCnt == 8)
			begin
				masterAck = ~sda;
				bitCnt = 9;
			end
		end
	end

	//////////////////////////////
	// SDA changes only while SCL is low
	//////////////////////////////
	always @(negedge scl)
	begin
		if (active)
		begin
			if (bitCnt == 8)
			begin
				// Acknowledge slot
				if (addrPhase)
				begin
					matched = (shiftReg[7:1] == ADDR);
					rw = shiftReg[0];
					sdaLow = matched;
				end
				else if (!rw)
				begin
					dataQ.push_back(shiftReg);
					sdaLow = 1'b1;
				end
				else
					sdaLow = 1'b0;
			end
			else if (bitCnt == 9)
			begin
				bitCnt = 0;
				sdaLow = 1'b0;
				if (!matched)
					active = 1'b0;
				else if (rw && (addrPhase || masterAck))
				begin
					// Empty queue reads back as all ones
					rdByte = (dataQ.size() > 0) ? dataQ.pop_front() : 8'hFF;
					sdaLow = ~rdByte[7];
				end
				addrPhase = 1'b0;
			end
			else if (matched && rw && !addrPhase && bitCnt > 0)
				sdaLow = ~rdByte[7 - bitCnt];
		end
	end

	// Clock stretch after each falling SCL edge while addressed
	always @(negedge scl)
	begin
		if (active && stretchCycles > 0)
		begin
			sclLow = 1'b1;
			repeat (stretchCycles) @(posedge PCLK);
			sclLow <= 1'b0;
		end
	end

endmodule

/* verif/tbClock.sv */
// Testbench clock and reset source, 40 ns PCLK with reset held low for five cycles
`timescale 1ns/10ps

module tbClock #(
	parameter int RESET_CYCLES = 5
) (
	output	logic	PCLK,
	output	logic	PRESETn
);
	initial
	begin
		PCLK = 1'b0;
		PRESETn = 1'b0;
		// Release reset on a rising edge, like every other driven input
		repeat (RESET_CYCLES) @(posedge PCLK);
		PRESETn <= 1'b1;
	end

	// Half period of 20 ns
	always #20 PCLK = ~PCLK;

endmodule
